// File: dv/mips_checker.sv
module mips_checker (
  input  logic        i_clk,
  input  logic        i_rst_n,
  input  logic        i_wb_valid,
  input  logic [4:0]  i_wb_reg,
  input  logic [31:0] i_wb_data,
  input  logic        i_st_valid,
  input  logic [29:0] i_st_addr,
  input  logic [31:0] i_st_data,
  input  logic [3:0]  i_st_be
);

  typedef struct packed {
    logic [4:0]  rg;
    logic [31:0] data;
  } wb_ev_t;

  typedef struct packed {
    logic [29:0] addr; // word address
    logic [3:0]  be;
    logic [31:0] data;
  } st_ev_t;

  wb_ev_t wb_q [$];   // expected writes, program order
  st_ev_t st_q [$];   // expected stores, program order
  string  test_name = "none";
  int     test_errs;
  int     err_count;
  int     tests_run;
  int     tests_failed;

  task automatic note_error();
    test_errs++;
    err_count++;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errs = 0;
    wb_q.delete();
    st_q.delete();
  endtask

  task automatic expect_write(input logic [4:0] rg, input logic [31:0] data);
    wb_ev_t ev;
    ev.rg   = rg;
    ev.data = data;
    wb_q.push_back(ev);
  endtask

  task automatic expect_store(input logic [29:0] addr, input logic [3:0] be,
                              input logic [31:0] data);
    st_ev_t ev;
    ev.addr = addr;
    ev.be   = be;
    ev.data = data;
    st_q.push_back(ev);
  endtask

  // called once the pipeline has drained
  task automatic end_test();
    if (wb_q.size() != 0) begin
      $display("%s: %0d expected register writes never appeared, first is r%0d",
               test_name, wb_q.size(), wb_q[0].rg);
      test_errs += wb_q.size();
      err_count += wb_q.size();
    end
    if (st_q.size() != 0) begin
      $display("%s: %0d expected stores never appeared, first at word %h",
               test_name, st_q.size(), st_q[0].addr);
      test_errs += st_q.size();
      err_count += st_q.size();
    end
    tests_run++;
    if (test_errs != 0) begin
      tests_failed++;
      $display("test %-12s failed with %0d errors", test_name, test_errs);
    end else begin
      $display("test %-12s ok", test_name);
    end
  endtask

  task automatic print_totals();
    $display("totals: %0d tests, %0d passed, %0d failed, %0d errors",
             tests_run, tests_run - tests_failed, tests_failed, err_count);
  endtask

  task automatic check_write();
    wb_ev_t exp;
    if (wb_q.size() == 0) begin
      $display("%s: unexpected register write r%0d = %h", test_name, i_wb_reg, i_wb_data);
      note_error();
    end else begin
      exp = wb_q.pop_front();
      if (exp.rg !== i_wb_reg || exp.data !== i_wb_data) begin
        $display("[FAIL] %s: write expected r%0d=%h actual r%0d=%h",
                 test_name, exp.rg, exp.data, i_wb_reg, i_wb_data);
        note_error();
      end
    end
  endtask

  task automatic check_store();
    st_ev_t exp;
    if (st_q.size() == 0) begin
      $display("%s: unexpected store to word %h be %b data %h",
               test_name, i_st_addr, i_st_be, i_st_data);
      note_error();
    end else begin
      exp = st_q.pop_front();
      if (exp.addr !== i_st_addr || exp.be !== i_st_be || exp.data !== i_st_data) begin
        $display("[FAIL] %s: store expected addr=%h be=%b data=%h actual addr=%h be=%b data=%h",
                 test_name, exp.addr, exp.be, exp.data, i_st_addr, i_st_be, i_st_data);
        note_error();
      end
    end
  endtask

  // sample on the edge, outputs still hold the previous cycle's values
  always @(posedge i_clk) begin
    if (i_rst_n) begin
      if ($isunknown({i_wb_valid, i_st_valid})) begin
        $display("%s: write-back or store valid is unknown", test_name);
        note_error();
      end
      if (i_wb_valid === 1'b1) check_write();
      if (i_st_valid === 1'b1) check_store();
    end
  end

endmodule

// File: dv/mips_vectors.txt
# T name | I instr_hex | W reg_dec data_hex | S word_addr_hex be_hex data_hex
# W and S lines list the events expected from the instructions above them, in order
T imm_ops
I 2001fffb  addi r1, r0, -5
W 1 fffffffb
I 34028001  ori r2, r0, 0x8001 zero extended
W 2 00008001
I 3c031234  lui r3, 0x1234
W 3 12340000
I 3024f0f0  andi r4, r1, 0xf0f0
W 4 0000f0f0
I 3865ffff  xori r5, r3, 0xffff
W 5 1234ffff
I 2826fffc  slti r6, r1, -4
W 6 00000001
I 2c478000  sltiu r7, r2, 0x8000 against 0xffff8000
W 7 00000001
T rtype
I 00434022  sub r8, r2, r3 wraps
W 8 edcc8001
I 00254821  addu r9, r1, r5
W 9 1234fffa
I 00655024  and r10, r3, r5
W 10 12340000
I 00445825  or r11, r2, r4
W 11 0000f0f1
I 00656026  xor r12, r3, r5
W 12 0000ffff
I 00046827  nor r13, r0, r4
W 13 ffff0f0f
I 0022702a  slt r14, r1, r2 signed
W 14 00000001
I 0022782b  sltu r15, r1, r2 unsigned
W 15 00000000
I 00068023  subu r16, r0, r6
W 16 ffffffff
I 00638820  add r17, r3, r3
W 17 24680000
T forwarding
I 20140007  addi r20, r0, 7
W 20 00000007
I 0294a820  add r21, r20, r20 distance 1
W 21 0000000e
I 02b4b022  sub r22, r21, r20 distance 1 and 2
W 22 00000007
I 0295b825  or r23, r20, r21 distance 3 and 2
W 23 0000000f
I 26f80010  addiu r24, r23, 0x10
W 24 0000001f
I 02d8c826  xor r25, r22, r24 distance 3 and 1
W 25 00000018
T stores
I 201a0040  addi r26, r0, 0x40 base
W 26 00000040
I af430008  sw r3, 8(r26)
S 12 f 12340000
I a7490006  sh r9, 6(r26) upper half
S 11 c fffafffa
I a354ffff  sb r20, -1(r26) negative offset
S f 8 07070707
I a3590049  sb r25, 0x49(r26)
S 22 2 18181818
I a7480004  sh r8, 4(r26) lower half
S 11 3 80018001
I 201b05a5  addi r27, r0, 0x5a5
W 27 000005a5
I af5b0000  sw r27, 0(r26) store data forwarded
S 10 f 000005a5
T loads
I 8f410008  lw r1, 8(r26)
W 1 12340000
I 34020003  ori r2, r0, 3 gap
W 2 00000003
I 00221821  addu r3, r1, r2
W 3 12340003
I 93440007  lbu r4, 7(r26)
W 4 000000ff
I 97450006  lhu r5, 6(r26)
W 5 0000fffa
I 97460004  lhu r6, 4(r26)
W 6 00008001
I 00853820  add r7, r4, r5
W 7 000100f9
I 9348ffff  lbu r8, -1(r26)
W 8 00000007
I 93490049  lbu r9, 0x49(r26)
W 9 00000018
I 00c85025  or r10, r6, r8
W 10 00008007
I 8f4b0000  lw r11, 0(r26)
W 11 000005a5
T r0_and_bad
I 20000055  addi r0, r0, 0x55 still reported
W 0 00000055
I 08000010  j, not decoded
I 00016080  sll, funct outside the set
I 10000004  beq, not decoded
I 20000077  addi r0, r0, 0x77
W 0 00000077
I 00026021  addu r12, r0, r2 right after the r0 write
W 12 00000003
I 00006825  or r13, r0, r0
W 13 00000000
I ab430000  swl, no store expected
I 83410008  lb, signed load left out

// File: dv/tb_mips_core.sv
module tb_mips_core;

  localparam int MAX_REC    = 256;
  localparam int DMEM_WORDS = 64;

  logic        clk;
  logic        rst_n;
  logic        instr_valid;
  logic [31:0] instr;
  logic        wb_valid;
  logic [4:0]  wb_reg;
  logic [31:0] wb_data;
  logic        st_valid;
  logic [29:0] st_addr;
  logic [31:0] st_data;
  logic [3:0]  st_be;

  // parsed records with the record letter as kind
  byte         rec_kind [MAX_REC];
  logic [31:0] rec_a    [MAX_REC]; // instruction, reg or word address
  logic [31:0] rec_b    [MAX_REC]; // write data or byte enables
  logic [31:0] rec_c    [MAX_REC]; // store data
  string       rec_name [MAX_REC];
  int          n_rec;
  int          n_instr;
  int          n_tests;
  int          cycles;
  int          cycle_limit;
  bit          vec_ok;

  mips_core_top #(
    .DMEM_WORDS (DMEM_WORDS)
  ) mips_core_top_i (
    .i_clk         (clk),
    .i_rst_n       (rst_n),
    .i_instr_valid (instr_valid),
    .i_instr       (instr),
    .o_wb_valid    (wb_valid),
    .o_wb_reg      (wb_reg),
    .o_wb_data     (wb_data),
    .o_st_valid    (st_valid),
    .o_st_addr     (st_addr),
    .o_st_data     (st_data),
    .o_st_be       (st_be)
  );

  mips_checker checker_i (
    .i_clk      (clk),
    .i_rst_n    (rst_n),
    .i_wb_valid (wb_valid),
    .i_wb_reg   (wb_reg),
    .i_wb_data  (wb_data),
    .i_st_valid (st_valid),
    .i_st_addr  (st_addr),
    .i_st_data  (st_data),
    .i_st_be    (st_be)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: %0d cycles passed and the vectors did not finish", cycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  task automatic load_vectors(output bit ok);
    int          fd;
    int          got;
    int          need;
    int          bad;
    string       line;
    string       tname;
    byte         kind;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    ok  = 1'b0;
    bad = 0;
    fd  = $fopen("dv/mips_vectors.txt", "r");
    if (fd == 0) return;
    while ($fgets(line, fd) != 0) begin
      got  = 0;
      kind = (line.len() > 1) ? line.getc(0) : 8'd0;
      case (kind)
        "T": begin
          got  = $sscanf(line, "T %s", tname);
          need = 1;
        end
        "I": begin
          got  = $sscanf(line, "I %h", a);
          need = 1;
        end
        "W": begin
          got  = $sscanf(line, "W %d %h", a, b);
          need = 2;
        end
        "S": begin
          got  = $sscanf(line, "S %h %h %h", a, b, c);
          need = 3;
        end
        default: need = 0; // comment or blank line
      endcase
      if (need > 0 && (got != need || n_rec >= MAX_REC)) begin
        $display("vector line could not be used: %s", line);
        bad++;
      end else if (need > 0) begin
        rec_kind[n_rec] = kind;
        rec_name[n_rec] = tname;
        rec_a[n_rec]    = a;
        rec_b[n_rec]    = b;
        rec_c[n_rec]    = c;
        n_rec++;
        if (kind == "T") n_tests++;
        if (kind == "I") n_instr++;
      end
    end
    $fclose(fd);
    ok = (bad == 0) && (n_tests > 0);
  endtask

  // the last store shows 3 edges and the last write 4 edges after it is driven
  task automatic drain_pipeline();
    @(posedge clk);
    instr_valid <= 1'b0;
    instr       <= '0;
    repeat (3) @(posedge clk);
    @(negedge clk); // checker has seen the final edge
  endtask

  initial begin
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    cycle_limit = 1000;
    load_vectors(vec_ok);
    if (!vec_ok) begin
      $display("no usable vectors in dv/mips_vectors.txt");
      $display("Simulation FAILED");
      $finish;
    end else begin
      cycle_limit = 4 + n_instr + 5 * n_tests + 20; // reset, one slot per word, drain per test
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      for (int r = 0; r < n_rec; r++) begin
        case (rec_kind[r])
          "T": begin
            if (r > 0) begin
              drain_pipeline();
              checker_i.end_test();
            end
            checker_i.start_test(rec_name[r]);
          end
          "W": checker_i.expect_write(rec_a[r][4:0], rec_b[r]);
          "S": checker_i.expect_store(rec_a[r][29:0], rec_b[r][3:0], rec_c[r]);
          default: begin
            @(posedge clk);
            instr_valid <= 1'b1;
            instr       <= rec_a[r];
          end
        endcase
      end
      drain_pipeline();
      checker_i.end_test();
      checker_i.print_totals();
      if (checker_i.err_count == 0 && checker_i.tests_run == n_tests) begin
        $display("Simulation PASSED");
      end else begin
        $display("Simulation FAILED");
      end
      $finish;
    end
  end

endmodule

// File: rtl/mips_control.sv
module mips_control (
  input  logic [5:0]      i_opcode,
  input  logic [5:0]      i_funct,
  output mips_pkg::ctrl_t o_ctrl
);
  import mips_pkg::*;

  // opcodes in scope, jumps and branches not decoded
  localparam logic [5:0] OP_RTYPE = 6'b000000;
  localparam logic [5:0] OP_ADDI  = 6'b001000;
  localparam logic [5:0] OP_ADDIU = 6'b001001;
  localparam logic [5:0] OP_SLTI  = 6'b001010;
  localparam logic [5:0] OP_SLTIU = 6'b001011;
  localparam logic [5:0] OP_ANDI  = 6'b001100;
  localparam logic [5:0] OP_ORI   = 6'b001101;
  localparam logic [5:0] OP_XORI  = 6'b001110;
  localparam logic [5:0] OP_LUI   = 6'b001111;
  localparam logic [5:0] OP_LW    = 6'b100011;
  localparam logic [5:0] OP_LBU   = 6'b100100;
  localparam logic [5:0] OP_LHU   = 6'b100101;
  localparam logic [5:0] OP_SB    = 6'b101000;
  localparam logic [5:0] OP_SH    = 6'b101001;
  localparam logic [5:0] OP_SW    = 6'b101011;

  logic funct_ok; // r-type funct is one we execute

  assign funct_ok = i_funct inside {F_ADD, F_ADDU, F_SUB, F_SUBU, F_AND,
                                    F_OR, F_XOR, F_NOR, F_SLT, F_SLTU};

  always_comb begin
    o_ctrl = '0; // anything not listed becomes a bubble
    case (i_opcode)
      OP_RTYPE: begin
        if (funct_ok) begin
          o_ctrl.regdst   = 1'b1; // result to rd
          o_ctrl.regwrite = 1'b1;
          o_ctrl.aluop    = {IOP_ADD, ALUOP_RTYPE};
        end
      end
      OP_ADDI, OP_ADDIU: begin // no overflow trap, both just add
        o_ctrl.regwrite = 1'b1;
        o_ctrl.alusrc   = 1'b1;
        o_ctrl.ifsign   = 1'b1;
        o_ctrl.aluop    = {IOP_ADD, ALUOP_IMM};
      end
      OP_ANDI, OP_ORI, OP_XORI: begin
        o_ctrl.regwrite = 1'b1;
        o_ctrl.alusrc   = 1'b1; // ifsign stays 0, logic imm is zero extended
        case (i_opcode[1:0])
          2'b00:   o_ctrl.aluop = {IOP_AND, ALUOP_IMM};
          2'b01:   o_ctrl.aluop = {IOP_OR, ALUOP_IMM};
          default: o_ctrl.aluop = {IOP_XOR, ALUOP_IMM};
        endcase
      end
      OP_SLTI: begin
        o_ctrl.regwrite = 1'b1;
        o_ctrl.alusrc   = 1'b1;
        o_ctrl.ifsign   = 1'b1;
        o_ctrl.aluop    = {IOP_SLT, ALUOP_IMM};
      end
      OP_SLTIU: begin // imm still sign extended, compare is unsigned
        o_ctrl.regwrite = 1'b1;
        o_ctrl.alusrc   = 1'b1;
        o_ctrl.ifsign   = 1'b1;
        o_ctrl.aluop    = {IOP_SLTU, ALUOP_IMM};
      end
      OP_LUI: begin
        o_ctrl.regwrite = 1'b1;
        o_ctrl.alusrc   = 1'b1;
        o_ctrl.aluop    = {IOP_LUI, ALUOP_IMM};
      end
      OP_LW, OP_LBU, OP_LHU: begin
        o_ctrl.regwrite = 1'b1;
        o_ctrl.alusrc   = 1'b1;
        o_ctrl.memread  = 1'b1;
        o_ctrl.memtoreg = 1'b1;
        o_ctrl.ifsign   = 1'b1; // signed offset
        o_ctrl.aluop    = {IOP_ADD, ALUOP_MEM};
        if (i_opcode == OP_LBU) o_ctrl.loadsig = W_BYTE;
        else if (i_opcode == OP_LHU) o_ctrl.loadsig = W_HALF;
      end
      OP_SB, OP_SH, OP_SW: begin
        o_ctrl.alusrc   = 1'b1;
        o_ctrl.memwrite = 1'b1; // no regwrite for stores
        o_ctrl.ifsign   = 1'b1;
        o_ctrl.aluop    = {IOP_ADD, ALUOP_MEM};
        case (i_opcode[1:0]) // width from opcode low bits
          2'b00:   o_ctrl.loadsig = W_BYTE;
          2'b01:   o_ctrl.loadsig = W_HALF;
          default: o_ctrl.loadsig = W_WORD;
        endcase
      end
      default: ;
    endcase
  end

endmodule

// File: rtl/mips_core_top.sv
module mips_core_top #(
  parameter int DMEM_WORDS = mips_pkg::DMEM_WORDS
) (
  input  logic        i_clk,
  input  logic        i_rst_n,
  input  logic        i_instr_valid,
  input  logic [31:0] i_instr,
  output logic        o_wb_valid,
  output logic [4:0]  o_wb_reg,
  output logic [31:0] o_wb_data,
  output logic        o_st_valid,
  output logic [29:0] o_st_addr,
  output logic [31:0] o_st_data,
  output logic [3:0]  o_st_be
);
  import mips_pkg::*;

  id_ex_t  id_ex;
  ex_mem_t ex_mem;
  mem_wb_t mem_wb;  // also the register file write port

  mips_decode_stage mips_decode_stage_i (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_instr_valid (i_instr_valid),
    .i_instr       (instr_u'(i_instr)),
    .i_wb          (mem_wb),
    .o_id_ex       (id_ex)
  );

  mips_execute_stage mips_execute_stage_i (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_id_ex     (id_ex),
    .i_ex_mem_fb (ex_mem),
    .i_mem_wb_fb (mem_wb),
    .o_ex_mem    (ex_mem)
  );

  mips_memory_stage #(
    .DMEM_WORDS (DMEM_WORDS)
  ) mips_memory_stage_i (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_ex_mem   (ex_mem),
    .o_mem_wb   (mem_wb),
    .o_st_valid (o_st_valid),
    .o_st_addr  (o_st_addr),
    .o_st_data  (o_st_data),
    .o_st_be    (o_st_be)
  );

  // r0 writes still show here, the register file drops them
  assign o_wb_valid = mem_wb.valid && mem_wb.regwrite;
  assign o_wb_reg   = mem_wb.dst;
  assign o_wb_data  = mem_wb.data;

endmodule

// File: rtl/mips_decode_stage.sv
module mips_decode_stage (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_instr_valid,
  input  mips_pkg::instr_u  i_instr,
  input  mips_pkg::mem_wb_t i_wb,     // write port from mem/wb
  output mips_pkg::id_ex_t  o_id_ex
);
  import mips_pkg::*;

  ctrl_t       ctrl;
  logic [4:0]  dst;
  logic [31:0] rda;
  logic [31:0] rdb;
  logic [31:0] imm_ext;

  mips_control mips_control_i (
    .i_opcode (i_instr.r.opcode),
    .i_funct  (i_instr.r.funct),
    .o_ctrl   (ctrl)
  );

  mips_regfile mips_regfile_i (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_ra    (i_instr.r.rs),
    .i_rb    (i_instr.r.rt),
    .o_rda   (rda),
    .o_rdb   (rdb),
    .i_wb    (i_wb)
  );

  assign dst = ctrl.regdst ? i_instr.r.rd : i_instr.i.rt; // rd for r-type

  // logic immediates arrive with ifsign clear and get zero extension
  assign imm_ext = ctrl.ifsign ? {{16{i_instr.i.imm[15]}}, i_instr.i.imm}
                               : {16'h0, i_instr.i.imm};

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_id_ex <= '0;
    end else begin
      o_id_ex.valid <= i_instr_valid;
      o_id_ex.ctrl  <= ctrl;          // zero ctrl is a bubble
      o_id_ex.rs    <= i_instr.r.rs;
      o_id_ex.rt    <= i_instr.r.rt;
      o_id_ex.dst   <= dst;
      o_id_ex.opa   <= rda;
      o_id_ex.opb   <= rdb;
      o_id_ex.imm   <= imm_ext;
      o_id_ex.funct <= i_instr.r.funct;
    end
  end

  // a strobed word and the operands it reads must be fully known
  a_no_x: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    i_instr_valid |-> !$isunknown({i_instr, rda, rdb})
  );

endmodule

// File: rtl/mips_execute_stage.sv
module mips_execute_stage (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  mips_pkg::id_ex_t  i_id_ex,
  input  mips_pkg::ex_mem_t i_ex_mem_fb, // distance 1 producer
  input  mips_pkg::mem_wb_t i_mem_wb_fb, // distance 2 producer
  output mips_pkg::ex_mem_t o_ex_mem
);
  import mips_pkg::*;

  logic [31:0] fwd_a;
  logic [31:0] fwd_b;   // also the store data
  logic [31:0] alu_b;
  logic [31:0] alu_res;

  // newest value of a source register, ex/mem before mem/wb
  function automatic logic [31:0] fwd(input logic [4:0]  src,
                                      input logic [31:0] rf_val,
                                      input ex_mem_t     em,
                                      input mem_wb_t     mw);
    logic hit_em;
    logic hit_mw;
    hit_em = em.valid && em.ctrl.regwrite && (em.dst != 5'd0) && (em.dst == src);
    hit_mw = mw.valid && mw.regwrite && (mw.dst != 5'd0) && (mw.dst == src);
    if (hit_em) return em.alu_res; // a load here is never consumed next
    else if (hit_mw) return mw.data;
    else return rf_val;
  endfunction

  assign fwd_a = fwd(i_id_ex.rs, i_id_ex.opa, i_ex_mem_fb, i_mem_wb_fb);
  assign fwd_b = fwd(i_id_ex.rt, i_id_ex.opb, i_ex_mem_fb, i_mem_wb_fb);
  assign alu_b = i_id_ex.ctrl.alusrc ? i_id_ex.imm : fwd_b;

  always_comb begin
    alu_res = '0;
    case (i_id_ex.ctrl.aluop[1:0])
      ALUOP_RTYPE: begin
        case (i_id_ex.funct)
          F_ADD, F_ADDU: alu_res = fwd_a + alu_b; // wraps, no trap
          F_SUB, F_SUBU: alu_res = fwd_a - alu_b;
          F_AND:         alu_res = fwd_a & alu_b;
          F_OR:          alu_res = fwd_a | alu_b;
          F_XOR:         alu_res = fwd_a ^ alu_b;
          F_NOR:         alu_res = ~(fwd_a | alu_b);
          F_SLT:         alu_res = {31'h0, $signed(fwd_a) < $signed(alu_b)};
          F_SLTU:        alu_res = {31'h0, fwd_a < alu_b};
          default: ;
        endcase
      end
      ALUOP_MEM: alu_res = fwd_a + alu_b; // byte address
      default: begin
        case (i_id_ex.ctrl.aluop[5:2])
          IOP_ADD:  alu_res = fwd_a + alu_b;
          IOP_AND:  alu_res = fwd_a & alu_b;
          IOP_OR:   alu_res = fwd_a | alu_b;
          IOP_XOR:  alu_res = fwd_a ^ alu_b;
          IOP_SLT:  alu_res = {31'h0, $signed(fwd_a) < $signed(alu_b)};
          IOP_SLTU: alu_res = {31'h0, fwd_a < alu_b};
          IOP_LUI:  alu_res = {alu_b[15:0], 16'h0}; // rs ignored
          default: ;
        endcase
      end
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_ex_mem <= '0;
    end else begin
      o_ex_mem.valid   <= i_id_ex.valid;
      o_ex_mem.ctrl    <= i_id_ex.ctrl;
      o_ex_mem.dst     <= i_id_ex.dst;
      o_ex_mem.alu_res <= alu_res;
      o_ex_mem.st_data <= fwd_b;
    end
  end

  // decoder never marks a store as writing a register
  a_st_no_wr: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (i_id_ex.valid && i_id_ex.ctrl.memwrite) |-> !i_id_ex.ctrl.regwrite
  );

endmodule

// File: rtl/mips_memory_stage.sv
module mips_memory_stage #(
  parameter int DMEM_WORDS = mips_pkg::DMEM_WORDS
) (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  mips_pkg::ex_mem_t i_ex_mem,
  output mips_pkg::mem_wb_t o_mem_wb,
  output logic              o_st_valid,
  output logic [29:0]       o_st_addr,   // word address
  output logic [31:0]       o_st_data,   // replicated into lanes
  output logic [3:0]        o_st_be
);
  import mips_pkg::*;

  localparam int ADDR_W = $clog2(DMEM_WORDS);

  logic [31:0]       dmem [DMEM_WORDS];
  logic [ADDR_W-1:0] widx;      // word index into dmem
  logic [1:0]        boff;      // byte offset in the word
  logic [31:0]       rd_word;
  logic [31:0]       ld_data;

  assign widx    = i_ex_mem.alu_res[ADDR_W+1:2];
  assign boff    = i_ex_mem.alu_res[1:0];
  assign rd_word = dmem[widx]; // async read in the mem cycle

  assign o_st_valid = i_ex_mem.valid && i_ex_mem.ctrl.memwrite;
  assign o_st_addr  = i_ex_mem.alu_res[31:2];

  always_comb begin
    o_st_be   = 4'b1111;
    o_st_data = i_ex_mem.st_data;
    case (i_ex_mem.ctrl.loadsig)
      W_HALF: begin
        o_st_be   = boff[1] ? 4'b1100 : 4'b0011;
        o_st_data = {2{i_ex_mem.st_data[15:0]}};
      end
      W_BYTE: begin
        o_st_be   = 4'b0001 << boff;
        o_st_data = {4{i_ex_mem.st_data[7:0]}};
      end
      default: ;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int k = 0; k < DMEM_WORDS; k++) begin
        dmem[k] <= '0;
      end
    end else if (o_st_valid) begin
      for (int b = 0; b < 4; b++) begin
        if (o_st_be[b]) dmem[widx][8*b +: 8] <= o_st_data[8*b +: 8];
      end
    end
  end

  // lbu / lhu pick a lane and zero extend
  always_comb begin
    ld_data = rd_word;
    case (i_ex_mem.ctrl.loadsig)
      W_BYTE:  ld_data = {24'h0, rd_word[8*boff +: 8]};
      W_HALF:  ld_data = {16'h0, (boff[1] ? rd_word[31:16] : rd_word[15:0])};
      default: ;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_mem_wb <= '0;
    end else begin
      o_mem_wb.valid    <= i_ex_mem.valid;
      o_mem_wb.regwrite <= i_ex_mem.valid && i_ex_mem.ctrl.regwrite;
      o_mem_wb.dst      <= i_ex_mem.dst;
      o_mem_wb.data     <= i_ex_mem.ctrl.memtoreg ? ld_data : i_ex_mem.alu_res;
    end
  end

  a_sw_align: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (o_st_valid && i_ex_mem.ctrl.loadsig == W_WORD) |-> (boff == 2'b00)
  );

  // address built in execute must land inside the array
  a_in_range: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (i_ex_mem.valid && (i_ex_mem.ctrl.memread || i_ex_mem.ctrl.memwrite))
      |-> (i_ex_mem.alu_res[31:2] < DMEM_WORDS)
  );

endmodule

// File: rtl/mips_pkg.sv
package mips_pkg;

  // data memory depth in 32-bit words, top level may override
  localparam int DMEM_WORDS = 64;

  // r-type funct codes that the core accepts
  localparam logic [5:0] F_ADD  = 6'b100000;
  localparam logic [5:0] F_ADDU = 6'b100001;
  localparam logic [5:0] F_SUB  = 6'b100010;
  localparam logic [5:0] F_SUBU = 6'b100011;
  localparam logic [5:0] F_AND  = 6'b100100;
  localparam logic [5:0] F_OR   = 6'b100101;
  localparam logic [5:0] F_XOR  = 6'b100110;
  localparam logic [5:0] F_NOR  = 6'b100111;
  localparam logic [5:0] F_SLT  = 6'b101010;
  localparam logic [5:0] F_SLTU = 6'b101011;

  // aluop upper nibble, immediate operation select
  localparam logic [3:0] IOP_ADD  = 4'b0000;
  localparam logic [3:0] IOP_AND  = 4'b0001;
  localparam logic [3:0] IOP_OR   = 4'b0010;
  localparam logic [3:0] IOP_XOR  = 4'b0011;
  localparam logic [3:0] IOP_SLT  = 4'b0110;
  localparam logic [3:0] IOP_LUI  = 4'b0111;
  localparam logic [3:0] IOP_SLTU = 4'b1001;

  // aluop low bits, instruction class
  localparam logic [1:0] ALUOP_MEM   = 2'b00; // load / store address add
  localparam logic [1:0] ALUOP_RTYPE = 2'b10; // op from funct
  localparam logic [1:0] ALUOP_IMM   = 2'b11; // op from upper nibble

  // loadsig, also the store width
  localparam logic [1:0] W_WORD = 2'b00;
  localparam logic [1:0] W_HALF = 2'b01;
  localparam logic [1:0] W_BYTE = 2'b10;

  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } r_fields_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } i_fields_t;

  // one instruction word, seen as r-type or i-type
  typedef union packed {
    r_fields_t r;
    i_fields_t i;
  } instr_u;

  typedef struct packed {
    logic       regdst;   // 1: dest is rd, 0: dest is rt
    logic       regwrite;
    logic       alusrc;   // 1: operand b is the immediate
    logic       memread;
    logic       memwrite;
    logic       memtoreg; // 1: write back load data
    logic       ifsign;   // 1: sign extend imm
    logic [1:0] loadsig;  // access width
    logic [5:0] aluop;
  } ctrl_t;

  typedef struct packed {
    logic        valid;
    ctrl_t       ctrl;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  dst;
    logic [31:0] opa;     // rs value from register file
    logic [31:0] opb;     // rt value from register file
    logic [31:0] imm;     // already extended
    logic [5:0]  funct;
  } id_ex_t;

  typedef struct packed {
    logic        valid;
    ctrl_t       ctrl;
    logic [4:0]  dst;
    logic [31:0] alu_res; // result or byte address
    logic [31:0] st_data; // forwarded rt
  } ex_mem_t;

  typedef struct packed {
    logic        valid;
    logic        regwrite;
    logic [4:0]  dst;
    logic [31:0] data;
  } mem_wb_t;

endpackage

// File: rtl/mips_regfile.sv
module mips_regfile (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic [4:0]        i_ra,
  input  logic [4:0]        i_rb,
  output logic [31:0]       o_rda,
  output logic [31:0]       o_rdb,
  input  mips_pkg::mem_wb_t i_wb
);

  logic [31:0] regs [32];
  logic        we;   // real write that skips r0

  assign we = i_wb.valid && i_wb.regwrite && (i_wb.dst != 5'd0);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int k = 0; k < 32; k++) begin
        regs[k] <= '0;
      end
    end else if (we) begin
      regs[i_wb.dst] <= i_wb.data;
    end
  end

  // write-through so a reader three slots behind sees the new value
  assign o_rda = (we && (i_wb.dst == i_ra)) ? i_wb.data : regs[i_ra];
  assign o_rdb = (we && (i_wb.dst == i_rb)) ? i_wb.data : regs[i_rb];

endmodule

// File: tb.f
rtl/mips_pkg.sv
rtl/mips_control.sv
rtl/mips_regfile.sv
rtl/mips_decode_stage.sv
rtl/mips_execute_stage.sv
rtl/mips_memory_stage.sv
rtl/mips_core_top.sv
dv/mips_checker.sv
dv/tb_mips_core.sv
